/* filelist.f */
+incdir+verilog
verilog/md_cache_pkg.sv
verilog/cell_ram.sv
verilog/pos_cache.sv
verilog/cache_ctrl_regs.sv
verilog/pos_cache_top.sv
testbench/pos_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the position cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module pos_cache_tb \
	-Mdir obj_dir

./obj_dir/Vpos_cache_tb > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"

/* testbench/pos_cache_tb.sv */
`include "md_cache_consts.svh"

module pos_cache_tb;

	import md_cache_pkg::*;

	localparam int NROWS = 12;
	localparam int NLOAD = 8;
	// Cell (2,1,1) is not in the store
	localparam logic [3*`CELL_ID_WIDTH-1:0] GHOST_ID = 12'h211;

	logic                        clk;
	logic                        rst;
	logic                        reg_wr;
	reg_addr_t                   reg_addr;
	logic [15:0]                 reg_wdata;
	logic [15:0]                 reg_rdata;
	logic                        mu_valid;
	logic [3*`CELL_ID_WIDTH-1:0] mu_dst_cell;
	logic [`POS_WIDTH-1:0]       mu_data;
	logic                        load_wr;
	logic                        load_cell;
	logic [`ADDR_WIDTH-1:0]      load_addr;
	logic [`POS_WIDTH-1:0]       load_data;
	logic                        rd_en;
	logic                        rd_cell;
	logic [`ADDR_WIDTH-1:0]      rd_addr;
	logic [`POS_WIDTH-1:0]       rd_data;

	integer seed;
	int errors;
	int checks;
	int err_mark;

	////////////////////////////////////////
	// Reference model, [cell][buffer][address]
	////////////////////////////////////////

	logic [`POS_WIDTH-1:0]       model [2][2][1 << `ADDR_WIDTH];
	logic                        act [2];
	// Highest address with known contents in the active buffer
	int                          lim [2];
	logic [`ADDR_WIDTH-1:0]      cnt [2];
	logic [15:0]                 gen_exp;
	logic [3*`CELL_ID_WIDTH-1:0] cell_id [2];

	// Broadcast table and the positions no cell may take
	logic [`POS_WIDTH-1:0]       tbl_pos [NROWS];
	logic [3*`CELL_ID_WIDTH-1:0] tbl_dst [NROWS];
	logic                        tbl_vld [NROWS];
	logic [`POS_WIDTH-1:0]       rej_q [$];

	pos_cache_top uut
	(
		.clk         (clk),
		.rst         (rst),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.mu_valid    (mu_valid),
		.mu_dst_cell (mu_dst_cell),
		.mu_data     (mu_data),
		.load_wr     (load_wr),
		.load_cell   (load_cell),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.rd_en       (rd_en),
		.rd_cell     (rd_cell),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Inputs change 2 units after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic check_pos(input string name, input logic [`POS_WIDTH-1:0] got,
		input logic [`POS_WIDTH-1:0] want);
		checks++;
		assert (got === want)
		else
		begin
			$display("MISMATCH %s got %h exp %h", name, got, want);
			errors++;
		end
	endtask

	// Register read data is combinational
	// Address held over one edge before the compare
	task automatic check_reg(input reg_addr_t a, input logic [15:0] want);
		reg_addr = a;
		step();
		checks++;
		assert (reg_rdata === want)
		else
		begin
			$display("MISMATCH reg_rdata[%s] got %h exp %h", a.name(), reg_rdata, want);
			errors++;
		end
	endtask

	task automatic write_reg(input reg_addr_t a, input logic [15:0] d);
		reg_wr = 1'b1;
		reg_addr = a;
		reg_wdata = d;
		step();
		reg_wr = 1'b0;
	endtask

	// Poll the busy bit, one cycle per try
	task automatic wait_idle();
		int n;
		n = 0;
		reg_addr = REG_STATUS;
		step();
		while (reg_rdata[0] && n < 40)
		begin
			step();
			n++;
		end
		if (reg_rdata[0])
		begin
			$display("Timeout waiting for the busy bit to clear");
			$display("Errors found");
			$finish;
		end
	endtask

	task automatic test_done(input int num, input string what);
		$display("Test %0d %s: %s", num, what, (errors == err_mark) ? "pass" : "FAIL");
		err_mark = errors;
	endtask

	// Random rows over both cells and the ghost cell
	// none set makes every row miss both cells
	task automatic fill_table(input bit none);
		integer r;
		rej_q.delete();
		for (int i = 0; i < NROWS; i++)
		begin
			tbl_pos[i] = {$random(seed), $random(seed), $random(seed)};
			r = $random(seed);
			case (r[1:0])
				2'd0: tbl_dst[i] = cell_id[0];
				2'd1: tbl_dst[i] = cell_id[1];
				2'd2: tbl_dst[i] = GHOST_ID;
				default: tbl_dst[i] = cell_id[r[3]];
			endcase
			tbl_vld[i] = (r[4:2] != 3'd0);
			if (none)
			begin
				if (r[5])
					tbl_dst[i] = GHOST_ID;
				else
					tbl_vld[i] = 1'b0;
			end
			if (!tbl_vld[i] || tbl_dst[i] == GHOST_ID)
				rej_q.push_back(tbl_pos[i]);
		end
	endtask

	task automatic read_check(input int c, input int a);
		rd_en = 1'b1;
		rd_cell = c[0];
		rd_addr = 8'(a);
		step();
		rd_en = 1'b0;
		check_pos($sformatf("rd_data cell %0d addr %0d", c, a), rd_data, model[c][act[c]][a]);
		// Count word never matches a random position
		if (a != 0)
		begin
			foreach (rej_q[k])
			begin
				assert (rd_data !== rej_q[k])
				else
				begin
					$display("Rejected particle %0d found in cell %0d at address %0d", k, c, a);
					errors++;
				end
			end
		end
	endtask

	task automatic readback();
		for (int c = 0; c < 2; c++)
			for (int a = 0; a <= lim[c]; a++)
				read_check(c, a);
	endtask

	////////////////////////////////////////
	// Motion update with reads to the old buffer
	////////////////////////////////////////

	task automatic run_update(input bit none);
		int rc;
		int ra;
		logic [`POS_WIDTH-1:0] exp_rd;
		fill_table(none);
		cnt[0] = '0;
		cnt[1] = '0;
		write_reg(REG_CTRL, 16'd1);
		for (int i = 0; i < NROWS; i++)
		begin
			mu_valid = tbl_vld[i];
			mu_dst_cell = tbl_dst[i];
			mu_data = tbl_pos[i];
			rc = i % 2;
			ra = i % (lim[rc] + 1);
			rd_en = 1'b1;
			rd_cell = rc[0];
			rd_addr = 8'(ra);
			exp_rd = model[rc][act[rc]][ra];
			// Accepted rows fill the shadow from address 1
			for (int c = 0; c < 2; c++)
			begin
				if (tbl_vld[i] && tbl_dst[i] == cell_id[c])
				begin
					cnt[c] = cnt[c] + 8'd1;
					model[c][!act[c]][cnt[c]] = tbl_pos[i];
				end
			end
			step();
			check_pos("rd_data during collect", rd_data, exp_rd);
		end
		mu_valid = 1'b0;
		rd_en = 1'b0;
		write_reg(REG_CTRL, 16'd0);
		wait_idle();
		// Count word, then swap
		for (int c = 0; c < 2; c++)
		begin
			model[c][!act[c]][0] = {{(`POS_WIDTH - `ADDR_WIDTH){1'b0}}, cnt[c]};
			act[c] = !act[c];
			lim[c] = int'(cnt[c]);
		end
		gen_exp = gen_exp + 16'd1;
		check_reg(REG_COUNT0, {8'd0, cnt[0]});
		check_reg(REG_COUNT1, {8'd0, cnt[1]});
		check_reg(REG_GEN, gen_exp);
		check_reg(REG_STATUS, 16'd0);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		seed = 79;
		clk = 1'b0;
		rst = 1'b1;
		reg_wr = 1'b0;
		reg_addr = REG_CTRL;
		reg_wdata = 16'd0;
		mu_valid = 1'b0;
		mu_dst_cell = '0;
		mu_data = '0;
		load_wr = 1'b0;
		load_cell = 1'b0;
		load_addr = '0;
		load_data = '0;
		rd_en = 1'b0;
		rd_cell = 1'b0;
		rd_addr = '0;
		errors = 0;
		checks = 0;
		err_mark = 0;
		gen_exp = 16'd0;
		cell_id[0] = `CELL0_ID;
		cell_id[1] = `CELL1_ID;
		act[0] = 1'b0;
		act[1] = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		// Registers clear, then preload buffer 0 of both cells
		check_reg(REG_CTRL, 16'd0);
		check_reg(REG_STATUS, 16'd0);
		check_reg(REG_GEN, 16'd0);
		check_reg(REG_COUNT0, 16'd0);
		check_reg(REG_COUNT1, 16'd0);
		for (int c = 0; c < 2; c++)
		begin
			for (int a = 0; a < NLOAD; a++)
			begin
				load_wr = 1'b1;
				load_cell = c[0];
				load_addr = 8'(a);
				load_data = {$random(seed), $random(seed), $random(seed)};
				model[c][act[c]][a] = load_data;
				step();
			end
			lim[c] = NLOAD - 1;
		end
		load_wr = 1'b0;
		readback();
		test_done(1, "reset and preload");

		run_update(1'b0);
		test_done(2, "first update with reads during collect");
		readback();
		test_done(3, "readback after swap");

		// Strobes with no enable go nowhere
		fill_table(1'b0);
		rej_q.delete();
		for (int i = 0; i < NROWS; i++)
		begin
			mu_valid = 1'b1;
			mu_dst_cell = cell_id[i % 2];
			mu_data = tbl_pos[i];
			rej_q.push_back(tbl_pos[i]);
			step();
		end
		mu_valid = 1'b0;
		readback();
		check_reg(REG_GEN, gen_exp);
		check_reg(REG_STATUS, 16'd0);
		test_done(4, "idle broadcast ignored");

		// Back to buffer 0, then an update that takes nothing
		run_update(1'b0);
		readback();
		run_update(1'b1);
		readback();
		test_done(5, "second and empty update");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* verilog/cache_ctrl_regs.sv */
`include "md_cache_consts.svh"

// Host register block
// Drives the update enable, records counts and swap generation
module cache_ctrl_regs
(
	input  logic                   clk,
	input  logic                   rst,
	// Host side
	input  logic                   reg_wr,
	input  md_cache_pkg::reg_addr_t reg_addr,
	input  logic [15:0]            reg_wdata,
	output logic [15:0]            reg_rdata,
	// Cache side
	input  logic [`CELL_NUM-1:0]   busy_in,
	input  logic [`CELL_NUM-1:0]   count_wr,
	input  logic [`ADDR_WIDTH-1:0] count_val0,
	input  logic [`ADDR_WIDTH-1:0] count_val1,
	output logic                   mu_enable
);

	import md_cache_pkg::*;

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	// Update enable level
	logic ctrl_en;
	// Number of buffer swaps so far
	logic [15:0] gen;
	// Last count reported by each cell
	logic [`ADDR_WIDTH-1:0] count0;
	logic [`ADDR_WIDTH-1:0] count1;

	// Only REG_CTRL is writable
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ctrl_en <= 1'b0;
		end
		else if (reg_wr && (reg_addr == REG_CTRL))
		begin
			ctrl_en <= reg_wdata[0];
		end
	end

	// Counts latch on each cell's pulse
	// Cell 0 pulse marks one swap
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count0 <= '0;
			count1 <= '0;
			gen <= '0;
		end
		else
		begin
			if (count_wr[0])
			begin
				count0 <= count_val0;
				gen <= gen + 1'b1;
			end
			if (count_wr[1])
			begin
				count1 <= count_val1;
			end
		end
	end

	assign mu_enable = ctrl_en;

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	always_comb
	begin
		case (reg_addr)
			REG_CTRL:   reg_rdata = {15'd0, ctrl_en};
			// Busy while any cell is past idle
			REG_STATUS: reg_rdata = {15'd0, |busy_in};
			REG_GEN:    reg_rdata = gen;
			REG_COUNT0: reg_rdata = {{(16 - `ADDR_WIDTH){1'b0}}, count0};
			REG_COUNT1: reg_rdata = {{(16 - `ADDR_WIDTH){1'b0}}, count1};
			default:    reg_rdata = 16'd0;
		endcase
	end

endmodule

/* verilog/cell_ram.sv */
`include "md_cache_consts.svh"

// Single port position RAM
// One cycle registered read, q holds between reads
module cell_ram
(
	input  logic                   clk,
	input  logic [`ADDR_WIDTH-1:0] addr,
	input  logic [`POS_WIDTH-1:0]  wdata,
	input  logic                   wren,
	input  logic                   rden,
	output logic [`POS_WIDTH-1:0]  q
);

	// Storage, one entry per address
	logic [`POS_WIDTH-1:0] mem [0:(1 << `ADDR_WIDTH) - 1];

	// Synchronous write
	always_ff @(posedge clk)
	begin
		if (wren)
		begin
			mem[addr] <= wdata;
		end
	end

	// Registered read
	// Output keeps last word when rden is low
	always_ff @(posedge clk)
	begin
		if (rden)
		begin
			q <= mem[addr];
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Port is shared, the buffer routing above must never
	// hand one RAM a write and a read together
	a_no_wr_rd: assert property (@(posedge clk) !(wren && rden))
		else $error("cell_ram: write and read in the same cycle");

endmodule

/* verilog/md_cache_consts.svh */
`ifndef MD_CACHE_CONSTS_SVH
`define MD_CACHE_CONSTS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// One coordinate word
`define DATA_WIDTH 32

// Packed position, MSB to LSB {posz, posy, posx}
`define POS_WIDTH (3 * `DATA_WIDTH)

// Cell address, entry 0 holds the particle count
`define ADDR_WIDTH 8

////////////////////////////////////////
// Cell geometry
////////////////////////////////////////

// Width of one cell coordinate
`define CELL_ID_WIDTH 4

// Number of cells in the store
`define CELL_NUM 2

// Packed cell IDs, MSB to LSB {cell_x, cell_y, cell_z}
// Cell (1,1,1)
`define CELL0_ID 12'h111
// Cell (1,1,2)
`define CELL1_ID 12'h112

`endif

/* verilog/md_cache_pkg.sv */
package md_cache_pkg;

	////////////////////////////////////////
	// Motion update FSM
	////////////////////////////////////////

	typedef enum logic [1:0]
	{
		// Waiting for the enable level
		MU_IDLE        = 2'd0,
		// Taking broadcast particles into the shadow buffer
		MU_COLLECT     = 2'd1,
		// Count goes to address 0 of the shadow buffer
		MU_WRITE_COUNT = 2'd2,
		// Shadow becomes active
		MU_SWAP        = 2'd3
	} mu_state_t;

	////////////////////////////////////////
	// Host register map
	////////////////////////////////////////

	typedef enum logic [2:0]
	{
		REG_CTRL   = 3'd0,   // bit 0 motion update enable
		REG_STATUS = 3'd1,   // bit 0 busy
		REG_GEN    = 3'd2,   // swap generation
		REG_COUNT0 = 3'd3,   // last count of cell 0
		REG_COUNT1 = 3'd4    // last count of cell 1
	} reg_addr_t;

endpackage

/* verilog/pos_cache.sv */
`include "md_cache_consts.svh"

// Double-buffered position cache of one cell
// Active buffer serves load and read, shadow buffer collects motion update
module pos_cache
#(
	parameter logic [3*`CELL_ID_WIDTH-1:0] CELL_ID = `CELL0_ID
)
(
	input  logic                       clk,
	input  logic                       rst,
	// Motion update broadcast
	input  logic                       mu_enable,
	input  logic                       mu_valid,
	input  logic [3*`CELL_ID_WIDTH-1:0] mu_dst_cell,
	input  logic [`POS_WIDTH-1:0]      mu_data,
	// Host preload of active buffer
	input  logic                       load_wr,
	input  logic [`ADDR_WIDTH-1:0]     load_addr,
	input  logic [`POS_WIDTH-1:0]      load_data,
	// Host read of active buffer
	input  logic                       rd_en,
	input  logic [`ADDR_WIDTH-1:0]     rd_addr,
	output logic [`POS_WIDTH-1:0]      rd_data,
	// Status toward register block
	output logic                       mu_busy,
	output logic                       count_wr,
	output logic [`ADDR_WIDTH-1:0]     count_val
);

	import md_cache_pkg::*;

	////////////////////////////////////////
	// Destination filter
	////////////////////////////////////////

	mu_state_t state;

	// Selects the active buffer, shadow is the other one
	logic active_buf;
	// Buffer that fed the last read
	logic rd_buf;
	// Next free shadow address, starts at 1 to skip the count word
	logic [`ADDR_WIDTH-1:0] counter;

	// Registered shadow write
	logic                   upd_wr;
	logic [`ADDR_WIDTH-1:0] upd_addr;
	logic [`POS_WIDTH-1:0]  upd_data;

	logic hit;
	logic collect_win;
	logic accept;

	// Particle addressed to this cell
	assign hit = mu_valid && (mu_dst_cell == CELL_ID);

	// First enable cycle counts too, then all of MU_COLLECT
	assign collect_win = ((state == MU_IDLE) && mu_enable) || (state == MU_COLLECT);
	assign accept = collect_win && hit;

	////////////////////////////////////////
	// Update FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= MU_IDLE;
			active_buf <= 1'b0;
			counter <= `ADDR_WIDTH'd1;
			upd_wr <= 1'b0;
		end
		else
		begin
			upd_wr <= 1'b0;
			case (state)
				MU_IDLE:
				begin
					if (mu_enable)
					begin
						state <= MU_COLLECT;
					end
				end
				MU_COLLECT:
				begin
					// Enable is a level, leave once it drops
					if (!mu_enable)
					begin
						state <= MU_WRITE_COUNT;
					end
				end
				MU_WRITE_COUNT:
				begin
					// Count word write
					upd_wr <= 1'b1;
					state <= MU_SWAP;
				end
				MU_SWAP:
				begin
					active_buf <= ~active_buf;
					counter <= `ADDR_WIDTH'd1;
					state <= MU_IDLE;
				end
				default:
				begin
					state <= MU_IDLE;
				end
			endcase
			// Accepted particle takes the next address
			if (accept)
			begin
				upd_wr <= 1'b1;
				counter <= counter + 1'b1;
			end
		end
	end

	// Shadow write address and data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			upd_addr <= counter;
			upd_data <= mu_data;
		end
		else if (state == MU_WRITE_COUNT)
		begin
			upd_addr <= '0;
			upd_data <= {{(`POS_WIDTH - `ADDR_WIDTH){1'b0}}, count_val};
		end
	end

	// Counter runs one ahead of the number of particles
	assign count_val = counter - 1'b1;
	assign count_wr = (state == MU_WRITE_COUNT);
	assign mu_busy = (state != MU_IDLE);

	////////////////////////////////////////
	// Buffer routing
	////////////////////////////////////////

	logic [`ADDR_WIDTH-1:0] ram_addr [2];
	logic [`POS_WIDTH-1:0]  ram_wdata [2];
	logic                   ram_wren [2];
	logic                   ram_rden [2];
	logic [`POS_WIDTH-1:0]  ram_q [2];

	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		logic is_active;
		assign is_active = (active_buf == b[0]);

		// Active side sees host traffic, shadow side sees update writes
		assign ram_addr[b]  = is_active ? (load_wr ? load_addr : rd_addr) : upd_addr;
		assign ram_wdata[b] = is_active ? load_data : upd_data;
		assign ram_wren[b]  = is_active ? load_wr : upd_wr;
		assign ram_rden[b]  = is_active ? rd_en : 1'b0;

		cell_ram u_ram
		(
			.clk   (clk),
			.addr  (ram_addr[b]),
			.wdata (ram_wdata[b]),
			.wren  (ram_wren[b]),
			.rden  (ram_rden[b]),
			.q     (ram_q[b])
		);
	end

	// Flag may flip between rd_en and data, so keep the one used for the read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_buf <= 1'b0;
		end
		else if (rd_en)
		begin
			rd_buf <= active_buf;
		end
	end

	assign rd_data = ram_q[rd_buf];

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Host preload only between updates
	a_no_load_busy: assert property (@(posedge clk) disable iff (rst) load_wr |-> !mu_busy)
		else $error("pos_cache: load_wr while motion update busy");

	// Counter at zero means the last address was used, next one would hit the count word
	a_no_addr_wrap: assert property (@(posedge clk) disable iff (rst) accept |-> (counter != '0))
		else $error("pos_cache: shadow address wrapped past maximum");

endmodule

/* verilog/pos_cache_top.sv */
`include "md_cache_consts.svh"

// Position store top
// Two cell caches behind one host register block
module pos_cache_top
(
	input  logic                        clk,
	input  logic                        rst,
	// Host registers
	input  logic                        reg_wr,
	input  md_cache_pkg::reg_addr_t     reg_addr,
	input  logic [15:0]                 reg_wdata,
	output logic [15:0]                 reg_rdata,
	// Motion update broadcast
	input  logic                        mu_valid,
	input  logic [3*`CELL_ID_WIDTH-1:0] mu_dst_cell,
	input  logic [`POS_WIDTH-1:0]       mu_data,
	// Preload
	input  logic                        load_wr,
	input  logic                        load_cell,
	input  logic [`ADDR_WIDTH-1:0]      load_addr,
	input  logic [`POS_WIDTH-1:0]       load_data,
	// Readback
	input  logic                        rd_en,
	input  logic                        rd_cell,
	input  logic [`ADDR_WIDTH-1:0]      rd_addr,
	output logic [`POS_WIDTH-1:0]       rd_data
);

	logic                   mu_enable;
	logic [`CELL_NUM-1:0]   mu_busy;
	logic [`CELL_NUM-1:0]   count_wr;
	logic [`ADDR_WIDTH-1:0] count_val [`CELL_NUM];
	logic [`POS_WIDTH-1:0]  cell_rd_data [`CELL_NUM];
	// Cell behind the read in flight
	logic                   rd_cell_q;

	////////////////////////////////////////
	// Cells
	////////////////////////////////////////

	for (genvar c = 0; c < `CELL_NUM; c++)
	begin : g_cell
		pos_cache
		#(
			.CELL_ID ((c == 0) ? `CELL0_ID : `CELL1_ID)
		)
		u_cache
		(
			.clk         (clk),
			.rst         (rst),
			.mu_enable   (mu_enable),
			.mu_valid    (mu_valid),
			.mu_dst_cell (mu_dst_cell),
			.mu_data     (mu_data),
			// Per cell strobes from the select bits
			.load_wr     (load_wr && (load_cell == c[0])),
			.load_addr   (load_addr),
			.load_data   (load_data),
			.rd_en       (rd_en && (rd_cell == c[0])),
			.rd_addr     (rd_addr),
			.rd_data     (cell_rd_data[c]),
			.mu_busy     (mu_busy[c]),
			.count_wr    (count_wr[c]),
			.count_val   (count_val[c])
		);
	end

	cache_ctrl_regs u_regs
	(
		.clk        (clk),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.busy_in    (mu_busy),
		.count_wr   (count_wr),
		.count_val0 (count_val[0]),
		.count_val1 (count_val[1]),
		.mu_enable  (mu_enable)
	);

	////////////////////////////////////////
	// Read return
	////////////////////////////////////////

	// Select follows RAM latency by one cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_cell_q <= 1'b0;
		end
		else if (rd_en)
		begin
			rd_cell_q <= rd_cell;
		end
	end

	assign rd_data = cell_rd_data[rd_cell_q];

endmodule
